/* dv/femtoCoreTb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the RV32I core
// Program assembly, expected-store table, store checks, watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module femtoCoreTb
   import rvIsaPkg::*;
;

   localparam logic [31:0] dataBase = 32'h300;
   localparam logic [31:0] loadAddr = 32'h3F0;
   localparam logic [31:0] loadWord = 32'h807FFF01;
   localparam logic [31:0] opA      = 32'hFFFFFFF9;
   localparam logic [31:0] opB      = 32'd100;

   logic        clk;
   logic        reset;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memWmask;
   logic        memRstrb, memRbusy, memWbusy;
   logic        storeValid;
   logic [31:0] storeAddr, storeData;
   logic [3:0]  storeMask;

   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   logic [3:0]  expMask [$];
   logic [31:0] gotAddr [$];
   logic [31:0] gotData [$];
   logic [3:0]  gotMask [$];
   logic [31:0] pc;
   logic [11:0] storeOff;
   logic [31:0] regVal [4];
   logic [2:0]  brF3 [6];
   int          errors;
   int          checks;
   logic        tableReady;
   logic        strobeLast;

   femtoCore femtoCore_i (
      .clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata, .memRstrb,
      .memRbusy, .memWbusy
   );

   tbMemory memory_i (
      .clk, .memAddr, .memWdata, .memWmask, .memRstrb, .memRdata, .memRbusy,
      .memWbusy, .storeValid, .storeAddr, .storeData, .storeMask
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Every store the core makes, in order
   always @(posedge clk) begin
      if (storeValid) begin
         gotAddr.push_back(storeAddr);
         gotData.push_back(storeData);
         gotMask.push_back(storeMask);
      end
   end

   // Read strobe lasts a single cycle
   always @(negedge clk) begin
      if (strobeLast) begin
         checkValue("read strobe width", 32'(memRstrb), 32'd0);
      end
      strobeLast = memRstrb;
   end

   // Instruction encoders
   function automatic logic [31:0] encI(logic [4:0] op, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [11:0] imm);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] encR(logic sub, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
      return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, opAluReg, 2'b11};
   endfunction

   function automatic logic [31:0] encS(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore, 2'b11};
   endfunction

   function automatic logic [31:0] encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch, 2'b11};
   endfunction

   function automatic logic [31:0] encU(logic [4:0] op, logic [4:0] rd, logic [19:0] imm);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] encJ(logic [4:0] rd, logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal, 2'b11};
   endfunction

   // RV32I branch conditions
   function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         f3Beq:   return a == b;
         f3Bne:   return a != b;
         f3Blt:   return $signed(a) < $signed(b);
         f3Bge:   return $signed(a) >= $signed(b);
         f3Bltu:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   // Load extraction, funct3 bit 2 means zero extend
   function automatic logic [31:0] loadValue(logic [31:0] w, int o, logic [2:0] f3);
      logic [7:0]  b;
      logic [15:0] h;
      b = w[8*o +: 8];
      h = w[16*(o/2) +: 16];
      if (f3[1:0] == sizeByte) begin
         return f3[2] ? {24'b0, b} : {{24{b[7]}}, b};
      end else if (f3[1:0] == sizeHalf) begin
         return f3[2] ? {16'b0, h} : {{16{h[15]}}, h};
      end
      return w;
   endfunction

   task automatic emit(logic [31:0] instr);
      memory_i.words[pc[9:2]] = instr;
      pc = pc + 4;
   endtask

   task automatic addExpect(logic [31:0] a, logic [31:0] d, logic [3:0] m);
      expAddr.push_back(a);
      expData.push_back(d);
      expMask.push_back(m);
   endtask

   // SW of one register to the next result slot
   task automatic saveReg(logic [4:0] rs, logic [31:0] value);
      emit(encS({1'b0, sizeWord}, rs, 5'd1, storeOff));
      addExpect(dataBase + storeOff, value, 4'hF);
      storeOff = storeOff + 4;
   endtask

   task automatic checkValue(string what, logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %0t: %s got %08h expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic buildProgram();
      logic [31:0] mark;
      logic [2:0]  ldF3 [9];
      int          ldOff [9];
      ldF3  = '{3'b000, 3'b000, 3'b000, 3'b100, 3'b100, 3'b001, 3'b001, 3'b101, 3'b010};
      ldOff = '{0, 1, 2, 1, 3, 0, 2, 2, 0};
      brF3  = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
      regVal[2] = opA;
      regVal[3] = opB;
      pc        = '0;
      storeOff  = '0;
      for (int i = 0; i < 256; i++) begin
         memory_i.words[i] = 32'hA5000000 ^ (i * 32'h00010101);
      end
      memory_i.words[loadAddr[9:2]] = loadWord;
      emit(encI(opAluImm, f3Add, 1, 0, dataBase[11:0]));
      emit(encI(opAluImm, f3Add, 2, 0, opA[11:0]));
      emit(encI(opAluImm, f3Add, 3, 0, opB[11:0]));
      // Arithmetic and logic
      emit(encR(0, f3Add, 4, 2, 3));
      saveReg(4, opA + opB);
      emit(encR(1, f3Add, 4, 2, 3));
      saveReg(4, opA - opB);
      emit(encI(opAluImm, f3Add, 4, 2, 12'd50));
      saveReg(4, opA + 32'd50);
      emit(encR(0, f3Xor, 4, 2, 3));
      saveReg(4, opA ^ opB);
      emit(encR(0, f3Or, 4, 2, 3));
      saveReg(4, opA | opB);
      emit(encR(0, f3And, 4, 2, 3));
      saveReg(4, opA & opB);
      emit(encR(0, f3Slt, 4, 2, 3));
      saveReg(4, {31'b0, $signed(opA) < $signed(opB)});
      emit(encR(0, f3Sltu, 4, 2, 3));
      saveReg(4, {31'b0, opA < opB});
      // Shifts of a negative value
      for (int k = 0; k < 3; k++) begin
         int amt;
         amt = (k == 0) ? 0 : (k == 1) ? 1 : 31;
         emit(encI(opAluImm, f3Add, 5, 0, 12'(amt)));
         emit(encR(0, f3Sll, 4, 2, 5));
         saveReg(4, opA << amt);
         emit(encR(0, f3Srl, 4, 2, 5));
         saveReg(4, opA >> amt);
         emit(encR(1, f3Srl, 4, 2, 5));
         saveReg(4, $signed(opA) >>> amt);
      end
      // Each branch skips the second marker when taken
      for (int p = 0; p < 3; p++) begin
         logic [4:0] ra;
         logic [4:0] rb;
         ra = (p == 0) ? 5'd2 : 5'd3;
         rb = (p == 1) ? 5'd2 : 5'd3;
         for (int j = 0; j < 6; j++) begin
            emit(encI(opAluImm, f3Add, 6, 0, 12'h011));
            emit(encB(brF3[j], ra, rb, 13'd8));
            emit(encI(opAluImm, f3Add, 6, 0, 12'h022));
            mark = branchTaken(brF3[j], regVal[ra], regVal[rb]) ? 32'h11 : 32'h22;
            saveReg(6, mark);
         end
      end
      // JAL over one instruction, link is its address plus 4
      emit(encI(opAluImm, f3Add, 6, 0, 12'h044));
      mark = pc;
      emit(encJ(7, 21'd8));
      emit(encI(opAluImm, f3Add, 6, 0, 12'h033));
      saveReg(6, 32'h44);
      saveReg(7, mark + 4);
      // JALR from an AUIPC base over two instructions
      mark = pc;
      emit(encU(opAuipc, 8, 20'h0));
      emit(encI(opJalr, 3'b000, 7, 8, 12'd16));
      emit(encI(opAluImm, f3Add, 6, 0, 12'h055));
      emit(encI(opAluImm, f3Add, 6, 0, 12'h066));
      saveReg(7, mark + 8);
      saveReg(6, 32'h44);
      mark = pc;
      emit(encU(opAuipc, 9, 20'h00001));
      saveReg(9, mark + 32'h1000);
      // LUI, then the low part for partial stores
      emit(encU(opLui, 10, 20'h12345));
      saveReg(10, 32'h12345000);
      emit(encI(opAluImm, f3Add, 10, 10, 12'h678));
      for (int o = 0; o < 4; o++) begin
         emit(encS({1'b0, sizeByte}, 10, 1, storeOff + 12'(o)));
         addExpect(dataBase + storeOff + o, {4{8'h78}}, 4'b0001 << o);
      end
      storeOff = storeOff + 4;
      for (int o = 0; o < 4; o += 2) begin
         emit(encS({1'b0, sizeHalf}, 10, 1, storeOff + 12'(o)));
         addExpect(dataBase + storeOff + o, {2{16'h5678}}, (o == 0) ? 4'b0011 : 4'b1100);
      end
      storeOff = storeOff + 4;
      // Loads from the preloaded word
      emit(encI(opAluImm, f3Add, 11, 0, loadAddr[11:0]));
      foreach (ldF3[k]) begin
         emit(encI(opLoad, ldF3[k], 12, 11, 12'(ldOff[k])));
         saveReg(12, loadValue(loadWord, ldOff[k], ldF3[k]));
      end
      // x0 ignores writes
      emit(encI(opAluImm, f3Add, 0, 0, 12'd5));
      saveReg(0, 32'h0);
      emit(encJ(0, 21'd0));
   endtask

   initial begin
      logic [31:0] lanes;
      reset      = 1'b0;
      errors     = 0;
      checks     = 0;
      strobeLast = 1'b0;
      tableReady = 1'b0;
      buildProgram();
      tableReady = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b1;
      for (int i = 0; i < expAddr.size(); i++) begin
         while (gotAddr.size() <= i) begin
            @(posedge clk);
         end
         // Only lanes under the mask carry store data
         for (int b = 0; b < 4; b++) begin
            lanes[8*b +: 8] = {8{expMask[i][b]}};
         end
         checkValue($sformatf("store %0d addr", i), gotAddr[i], expAddr[i]);
         checkValue($sformatf("store %0d mask", i), 32'(gotMask[i]), 32'(expMask[i]));
         checkValue($sformatf("store %0d data", i), gotData[i] & lanes, expData[i] & lanes);
      end
      repeat (50) @(posedge clk);
      checkValue("store count", 32'(gotAddr.size()), 32'(expAddr.size()));
      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog scaled by the number of expected stores
   initial begin
      while (!tableReady) begin
         @(posedge clk);
      end
      repeat (expAddr.size() * 200) @(posedge clk);
      $display("timeout: only %0d of %0d stores arrived", gotAddr.size(), expAddr.size());
      $display("errors: %0d, checks: %0d", errors + 1, checks);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* dv/tbMemory.sv */
//////////////////////////////////////////////////////////////////////
// Behavioural 256-word memory for the core testbench
// LFSR-driven read and write busy levels, store monitor outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbMemory (
   input  logic        clk,
   input  logic [31:0] memAddr,
   input  logic [31:0] memWdata,
   input  logic [3:0]  memWmask,
   input  logic        memRstrb,
   output logic [31:0] memRdata,
   output logic        memRbusy,
   output logic        memWbusy,
   output logic        storeValid,
   output logic [31:0] storeAddr,
   output logic [31:0] storeData,
   output logic [3:0]  storeMask
);

   logic [31:0] words [256];
   logic [15:0] lfsr;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   initial begin
      lfsr       = 16'd14664;
      memRdata   = '0;
      memRbusy   = 1'b0;
      memWbusy   = 1'b0;
      storeValid = 1'b0;
      storeAddr  = '0;
      storeData  = '0;
      storeMask  = '0;
   end

   always @(posedge clk) begin : memAccess
      logic        rstrb;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wmask;
      logic        rBit;
      logic        wBit;
      // Bus sampled right at the edge
      rstrb = memRstrb;
      addr  = memAddr;
      wdata = memWdata;
      wmask = memWmask;
      for (int b = 0; b < 4; b++) begin
         if (wmask[b]) begin
            words[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      // Responses change a little after the edge
      #1;
      rBit = lfsr[0];
      lfsr = lfsrNext(lfsr);
      wBit = lfsr[0];
      lfsr = lfsrNext(lfsr);
      storeValid = (wmask != '0);
      storeAddr  = addr;
      storeData  = wdata;
      storeMask  = wmask;
      if (rstrb) begin
         memRdata = words[addr[9:2]];
         memRbusy = rBit;
      end else begin
         // Stall ends at the first zero bit
         memRbusy = memRbusy & rBit;
      end
      memWbusy = (wmask != '0) ? wBit : (memWbusy & wBit);
   end

endmodule

/* run.sh */
#!/bin/bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter project directory"
   exit 1
fi

verilator --binary --timing -Wno-fatal --top-module femtoCoreTb \
   -f src.f --Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "compile failed, see build.log"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
   echo "simulation reported failure, see sim.log"
   exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
   echo "simulation ended without a result, see sim.log"
   exit 1
fi

echo "simulation passed"
exit 0

/* src.f */
verilog/rvIsaPkg.sv
verilog/coreCfgPkg.sv
verilog/rvDecoder.sv
verilog/regFile.sv
verilog/rvAlu.sv
verilog/loadStoreAlign.sv
verilog/controlFsm.sv
verilog/femtoCore.sv
dv/tbMemory.sv
dv/femtoCoreTb.sv

/* verilog/controlFsm.sv */
//////////////////////////////////////////////////////////////////////
// Control state machine
// One-hot states, program counter, target and address adders,
// bus address mux and register write-back selection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module controlFsm
   import rvIsaPkg::*;
   import coreCfgPkg::*;
(
   input  logic            clk,
   input  logic            reset,
   input  logic            memRbusy,
   input  logic            memWbusy,
   input  logic            isLoad,
   input  logic            isAluImm,
   input  logic            isAluReg,
   input  logic            isAuipc,
   input  logic            isStore,
   input  logic            isLui,
   input  logic            isBranch,
   input  logic            isJalr,
   input  logic            isJal,
   input  logic [xlen-1:0] iImm,
   input  logic [xlen-1:0] sImm,
   input  logic [xlen-1:0] bImm,
   input  logic [xlen-1:0] uImm,
   input  logic [xlen-1:0] jImm,
   input  logic [xlen-1:0] rs1,
   input  logic [xlen-1:0] aluPlus,
   input  logic [xlen-1:0] aluOut,
   input  logic            aluBusy,
   input  logic            predicateNext,
   input  logic [xlen-1:0] loadData,
   input  logic [3:0]      storeMask,
   output logic            instrLoad,
   output logic            aluWr,
   output logic            writeBack,
   output logic [xlen-1:0] writeBackData,
   output logic [xlen-1:0] memAddr,
   output logic            memRstrb,
   output logic [3:0]      memWmask,
   output logic [1:0]      byteOffset
);

   localparam int padWidth = xlen - addrWidth;

   logic [numStates-1:0] state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] loadStoreAddr;
   logic [addrWidth-1:0] pcImm;
   logic                 predicate;
   logic                 isAlu;
   logic                 needToWait;

   assign isAlu   = isAluImm | isAluReg;
   assign pcPlus4 = pc + 4;
   // Offset added to PC for JAL, AUIPC and branches
   assign pcImm = isJal   ? jImm[addrWidth-1:0] :
                  isAuipc ? uImm[addrWidth-1:0] :
                            bImm[addrWidth-1:0];

   // PC on the bus while fetching, else the load/store address
   assign memAddr    = {{padWidth{1'b0}},
                        (state[stFetch] | state[stWaitInstr]) ? pc : loadStoreAddr};
   assign byteOffset = loadStoreAddr[1:0];

   assign instrLoad = state[stWaitInstr] & ~memRbusy;
   assign aluWr     = state[stExec1] & isAlu;
   assign memRstrb  = state[stFetch] | (state[stExec2] & isLoad);
   assign memWmask  = {4{state[stExec2] & isStore}} & storeMask;

   // Repeats in the wait state so a load takes its final data
   assign writeBack = ~(isBranch | isStore) & (state[stExec2] | state[stWaitAluMem]);

   assign writeBackData = (isLui           ? uImm                             : '0) |
                          (isAlu           ? aluOut                           : '0) |
                          (isAuipc         ? {{padWidth{1'b0}}, pcPlusImm}    : '0) |
                          (isJal | isJalr  ? {{padWidth{1'b0}}, pcPlus4}      : '0) |
                          (isLoad          ? loadData                         : '0);

   // Every store waits for memWbusy
   assign needToWait = isLoad | isStore | aluBusy;

   // Targets and address registered in the first execute step
   always_ff @(posedge clk) begin
      if (state[stExec1]) begin
         pcPlusImm     <= pc + pcImm;
         loadStoreAddr <= rs1[addrWidth-1:0] +
                          (isStore ? sImm[addrWidth-1:0] : iImm[addrWidth-1:0]);
         predicate     <= predicateNext;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by draining any pending bus write
         state <= numStates'(1) << stWaitAluMem;
         pc    <= resetAddr;
      end else begin
         case (1'b1)
            state[stFetch]: state <= numStates'(1) << stWaitInstr;
            state[stWaitInstr]: begin
               if (!memRbusy) begin
                  state <= numStates'(1) << stExec1;
               end
            end
            state[stExec1]: state <= numStates'(1) << stExec2;
            state[stExec2]: begin
               if (isJalr) begin
                  pc <= {aluPlus[addrWidth-1:1], 1'b0};
               end else if (isJal | (isBranch & predicate)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= numStates'(1) << (needToWait ? stWaitAluMem : stFetch);
            end
            default: begin
               // Wait for shifter and bus to go idle
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= numStates'(1) << stFetch;
               end
            end
         endcase
      end
   end

endmodule

/* verilog/coreCfgPkg.sv */
//////////////////////////////////////////////////////////////////////
// Core organisation constants
// Internal address width, reset address, one-hot state indices
//////////////////////////////////////////////////////////////////////

package coreCfgPkg;

   // Address logic width, upper bus bits read as zero
   localparam int addrWidth = 24;

   // First instruction fetched after reset
   localparam logic [addrWidth-1:0] resetAddr = '0;

   // One-hot state bit positions
   localparam int stFetch      = 0;
   localparam int stWaitInstr  = 1;
   localparam int stExec1      = 2;
   localparam int stExec2      = 3;
   localparam int stWaitAluMem = 4;
   localparam int numStates    = 5;

endpackage

/* verilog/femtoCore.sv */
//////////////////////////////////////////////////////////////////////
// Multi-cycle RV32I core top level
// Decoder, register file, ALU, load/store alignment and control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module femtoCore (
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] memAddr,
   output logic [31:0] memWdata,
   output logic [3:0]  memWmask,
   input  logic [31:0] memRdata,
   output logic        memRstrb,
   input  logic        memRbusy,
   input  logic        memWbusy
);

   logic        instrLoad;
   logic        aluWr;
   logic        writeBack;
   logic [31:0] writeBackData;
   logic        isLoad, isAluImm, isAluReg, isAuipc, isStore;
   logic        isLui, isBranch, isJalr, isJal, useRs2;
   logic [7:0]  funct3Is;
   logic [4:0]  rdId;
   logic [31:0] iImm, sImm, bImm, uImm, jImm;
   logic        subOrArith;
   logic [1:0]  memSize;
   logic        loadUnsigned;
   logic [31:0] rs1, rs2;
   logic [31:0] aluOut, aluPlus;
   logic        aluBusy, predicateNext;
   logic [31:0] loadData;
   logic [3:0]  storeMask;
   logic [1:0]  byteOffset;

   rvDecoder decoder_i (
      .clk, .instrLoad, .memRdata, .isLoad, .isAluImm, .isAluReg, .isAuipc,
      .isStore, .isLui, .isBranch, .isJalr, .isJal, .useRs2, .funct3Is, .rdId,
      .iImm, .sImm, .bImm, .uImm, .jImm, .subOrArith, .memSize, .loadUnsigned
   );

   // Source indices taken from the bus word being latched
   regFile regFile_i (
      .clk, .instrLoad, .rs1Id(memRdata[19:15]), .rs2Id(memRdata[24:20]),
      .writeBack, .rdId, .writeBackData, .rs1, .rs2
   );

   rvAlu alu_i (
      .clk, .aluWr, .rs1, .rs2, .iImm, .useRs2, .funct3Is, .subOrArith,
      .isAluReg, .aluOut, .aluPlus, .aluBusy, .predicateNext
   );

   loadStoreAlign align_i (
      .memRdata, .rs2, .byteOffset, .memSize, .loadUnsigned, .loadData,
      .storeData(memWdata), .storeMask
   );

   controlFsm control_i (
      .clk, .reset, .memRbusy, .memWbusy, .isLoad, .isAluImm, .isAluReg,
      .isAuipc, .isStore, .isLui, .isBranch, .isJalr, .isJal, .iImm, .sImm,
      .bImm, .uImm, .jImm, .rs1, .aluPlus, .aluOut, .aluBusy, .predicateNext,
      .loadData, .storeMask, .instrLoad, .aluWr, .writeBack, .writeBackData,
      .memAddr, .memRstrb, .memWmask, .byteOffset
   );

endmodule

/* verilog/loadStoreAlign.sv */
//////////////////////////////////////////////////////////////////////
// Load and store alignment
// Byte/halfword extraction with sign extension, store data and mask
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module loadStoreAlign
   import rvIsaPkg::*;
(
   input  logic [xlen-1:0] memRdata,
   input  logic [xlen-1:0] rs2,
   input  logic [1:0]      byteOffset,
   input  logic [1:0]      memSize,
   input  logic            loadUnsigned,
   output logic [xlen-1:0] loadData,
   output logic [xlen-1:0] storeData,
   output logic [3:0]      storeMask
);

   logic       byteAccess;
   logic       halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (memSize == sizeByte);
   assign halfAccess = (memSize == sizeHalf);

   // Offset bit 1 picks the halfword, bit 0 the byte inside it
   assign loadHalf = byteOffset[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = byteOffset[0] ? loadHalf[15:8] : loadHalf[7:0];

   // LBU and LHU zero extend
   assign loadSign = ~loadUnsigned & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Low bytes of rs2 copied to every lane they may land in
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = byteOffset[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = byteOffset[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = byteOffset[0] ? rs2[7:0] :
                             byteOffset[1] ? rs2[15:8] : rs2[31:24];

   // One lane per byte, two per halfword, all four for a word
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << byteOffset;
      end else if (halfAccess) begin
         storeMask = byteOffset[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

/* verilog/regFile.sv */
//////////////////////////////////////////////////////////////////////
// Register file, 32 words
// Source operands registered when the instruction is latched
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module regFile
   import rvIsaPkg::*;
(
   input  logic                  clk,
   input  logic                  instrLoad,
   input  logic [regIdWidth-1:0] rs1Id,
   input  logic [regIdWidth-1:0] rs2Id,
   input  logic                  writeBack,
   input  logic [regIdWidth-1:0] rdId,
   input  logic [xlen-1:0]       writeBackData,
   output logic [xlen-1:0]       rs1,
   output logic [xlen-1:0]       rs2
);

   logic [xlen-1:0] regs [2**regIdWidth];

   // x0 stays zero, writes to it are dropped
   always_ff @(posedge clk) begin
      if (writeBack && rdId != '0) begin
         regs[rdId] <= writeBackData;
      end
   end

   // Indices come straight off the read bus
   always_ff @(posedge clk) begin
      if (instrLoad) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

/* verilog/rvAlu.sv */
//////////////////////////////////////////////////////////////////////
// ALU with serial shifter
// Adder, 33-bit subtract and compares, logic ops, branch predicate
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvAlu
   import rvIsaPkg::*;
(
   input  logic            clk,
   input  logic            aluWr,
   input  logic [xlen-1:0] rs1,
   input  logic [xlen-1:0] rs2,
   input  logic [xlen-1:0] iImm,
   input  logic            useRs2,
   input  logic [7:0]      funct3Is,
   input  logic            subOrArith,
   input  logic            isAluReg,
   output logic [xlen-1:0] aluOut,
   output logic [xlen-1:0] aluPlus,
   output logic            aluBusy,
   output logic            predicateNext
);

   logic [xlen-1:0]       aluIn2;
   logic [xlen:0]         aluMinus;
   logic                  lt;
   logic                  ltu;
   logic                  eq;
   logic                  isShift;
   logic                  isSub;
   logic [xlen-1:0]       aluReg;
   logic [shamtWidth-1:0] aluShamt;

   // rs2 for register ops and branches, else the I immediate
   assign aluIn2  = useRs2 ? rs2 : iImm;
   assign aluPlus = rs1 + aluIn2;

   // One subtract gives SUB and every compare
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[xlen];
   assign lt       = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : ltu;
   assign eq       = (aluMinus[xlen-1:0] == '0);

   // Bit 30 is part of the immediate for ADDI
   assign isSub   = subOrArith & isAluReg;
   assign isShift = funct3Is[f3Sll] | funct3Is[f3Srl];

   assign aluOut  = aluReg;
   // Still shifting while count nonzero
   assign aluBusy = |aluShamt;

   always_ff @(posedge clk) begin
      if (aluWr) begin
         aluShamt <= isShift ? aluIn2[shamtWidth-1:0] : '0;
         aluReg   <= (isShift          ? rs1                          : '0) |
                     (funct3Is[f3Add]  ? (isSub ? aluMinus[xlen-1:0]
                                                : aluPlus)            : '0) |
                     (funct3Is[f3Slt]  ? {{(xlen-1){1'b0}}, lt}       : '0) |
                     (funct3Is[f3Sltu] ? {{(xlen-1){1'b0}}, ltu}      : '0) |
                     (funct3Is[f3Xor]  ? rs1 ^ aluIn2                 : '0) |
                     (funct3Is[f3Or]   ? rs1 | aluIn2                 : '0) |
                     (funct3Is[f3And]  ? rs1 & aluIn2                 : '0);
      end else if (aluBusy) begin
         // One bit per cycle
         aluShamt <= aluShamt - 1'b1;
         if (funct3Is[f3Sll]) begin
            aluReg <= aluReg << 1;
         end else begin
            // SRA copies the sign bit, SRL shifts in zero
            aluReg <= {subOrArith & aluReg[xlen-1], aluReg[xlen-1:1]};
         end
      end
   end

   // Branch condition
   assign predicateNext = (funct3Is[f3Beq]  &  eq)  |
                          (funct3Is[f3Bne]  & ~eq)  |
                          (funct3Is[f3Blt]  &  lt)  |
                          (funct3Is[f3Bge]  & ~lt)  |
                          (funct3Is[f3Bltu] &  ltu) |
                          (funct3Is[f3Bgeu] & ~ltu);

endmodule

/* verilog/rvDecoder.sv */
//////////////////////////////////////////////////////////////////////
// Instruction latch and decoder
// Opcode class flags, one-hot funct3, immediates and mode bits
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvDecoder
   import rvIsaPkg::*;
(
   input  logic                  clk,
   input  logic                  instrLoad,
   input  logic [xlen-1:0]       memRdata,
   output logic                  isLoad,
   output logic                  isAluImm,
   output logic                  isAluReg,
   output logic                  isAuipc,
   output logic                  isStore,
   output logic                  isLui,
   output logic                  isBranch,
   output logic                  isJalr,
   output logic                  isJal,
   output logic                  useRs2,
   output logic [7:0]            funct3Is,
   output logic [regIdWidth-1:0] rdId,
   output logic [xlen-1:0]       iImm,
   output logic [xlen-1:0]       sImm,
   output logic [xlen-1:0]       bImm,
   output logic [xlen-1:0]       uImm,
   output logic [xlen-1:0]       jImm,
   output logic                  subOrArith,
   output logic [1:0]            memSize,
   output logic                  loadUnsigned
);

   // Bits 1 and 0 are always 11 in RV32I
   logic [xlen-1:2] instr;

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRdata[xlen-1:2];
      end
   end

   // Instruction class from the opcode field
   assign isLoad   = (instr[6:2] == opLoad);
   assign isAluImm = (instr[6:2] == opAluImm);
   assign isAluReg = (instr[6:2] == opAluReg);
   assign isAuipc  = (instr[6:2] == opAuipc);
   assign isStore  = (instr[6:2] == opStore);
   assign isLui    = (instr[6:2] == opLui);
   assign isBranch = (instr[6:2] == opBranch);
   assign isJalr   = (instr[6:2] == opJalr);
   assign isJal    = (instr[6:2] == opJal);

   // Second ALU operand is rs2 for register ops and compares
   assign useRs2 = isAluReg | isBranch;

   // funct3Is[n] set when funct3 equals n
   assign funct3Is = 8'b0000_0001 << instr[f3Lsb +: 3];
   assign rdId     = instr[rdLsb +: regIdWidth];

   // Immediate formats, all sign extended from bit 31
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign uImm = {instr[31], instr[30:12], 12'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // SUB and SRA select, also SRAI
   assign subOrArith   = instr[30];
   assign memSize      = instr[13:12];
   assign loadUnsigned = instr[14];

endmodule

/* verilog/rvIsaPkg.sv */
//////////////////////////////////////////////////////////////////////
// RV32I instruction-set constants
// Opcode field values, funct3 codes, memory access sizes,
// field positions and word widths
//////////////////////////////////////////////////////////////////////

package rvIsaPkg;

   // Word and field widths
   localparam int xlen       = 32;
   localparam int regIdWidth = 5;
   localparam int shamtWidth = 5;

   // Low bit of the rd and funct3 fields
   localparam int rdLsb = 7;
   localparam int f3Lsb = 12;

   // Opcode values, instruction bits 6 to 2
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;

   // ALU funct3 codes
   localparam logic [2:0] f3Add  = 3'd0;
   localparam logic [2:0] f3Sll  = 3'd1;
   localparam logic [2:0] f3Slt  = 3'd2;
   localparam logic [2:0] f3Sltu = 3'd3;
   localparam logic [2:0] f3Xor  = 3'd4;
   localparam logic [2:0] f3Srl  = 3'd5;
   localparam logic [2:0] f3Or   = 3'd6;
   localparam logic [2:0] f3And  = 3'd7;

   // Branch funct3 codes
   localparam logic [2:0] f3Beq  = 3'd0;
   localparam logic [2:0] f3Bne  = 3'd1;
   localparam logic [2:0] f3Blt  = 3'd4;
   localparam logic [2:0] f3Bge  = 3'd5;
   localparam logic [2:0] f3Bltu = 3'd6;
   localparam logic [2:0] f3Bgeu = 3'd7;

   // Low two funct3 bits of a load or store
   localparam logic [1:0] sizeByte = 2'b00;
   localparam logic [1:0] sizeHalf = 2'b01;
   localparam logic [1:0] sizeWord = 2'b10;

endpackage
